// File: design/bkt_pkg.sv
/*
 * shared widths, state words, AXI4-Lite channel structs and the register map.
 * register offsets are byte addresses on an 8-bit AXI4-Lite address bus.
 */
package bkt_pkg;

    localparam int VAR_LVL_W = 16;
    localparam int BIN_ID_W  = 10;
    localparam int NV_W      = 16;

    // variable RAM word, 19 bits
    typedef struct packed {
        logic [1:0]           value;
        logic                 tried;
        logic [VAR_LVL_W-1:0] lvl;
    } var_state_t;

    // level RAM word, 11 bits
    typedef struct packed {
        logic [BIN_ID_W-1:0] bin_id;
        logic                has_bkted;
    } lvl_state_t;

    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [NV_W-1:0]      nv_all;
        logic [VAR_LVL_W-1:0] bkt_lvl;
        logic [BIN_ID_W-1:0]  bkt_bin;
    } bkt_cfg_t;

    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_STATUS   = 8'h04;
    localparam logic [7:0] REG_NV_ALL   = 8'h08;
    localparam logic [7:0] REG_BKT_LVL  = 8'h0C;
    localparam logic [7:0] REG_BKT_BIN  = 8'h10;
    localparam logic [7:0] REG_VAR_ADDR = 8'h14;
    localparam logic [7:0] REG_VAR_DATA = 8'h18;
    localparam logic [7:0] REG_LVL_ADDR = 8'h1C;
    localparam logic [7:0] REG_LVL_DATA = 8'h20;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

endpackage

// File: design/state_ram.sv
/*
 * simple dual-port RAM, registered read with one cycle latency.
 * a read and write to the same address in one cycle return the old word.
 * contents are unknown after power-up.
 */
module state_ram #(
    parameter type word_t = logic [7:0],
    parameter int  ADDR_W = 9
) (
    input  logic              clk,
    input  logic              we_i,
    input  logic [ADDR_W-1:0] waddr_i,
    input  word_t             wdata_i,
    input  logic [ADDR_W-1:0] raddr_i,
    output word_t             rdata_o
);

    word_t mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read sees the word before this cycle's write
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// File: design/bkt_across_bin.sv
/*
 * backtrack sweep over variables 0..nv_all-1, fixed latency nv_all+3 from start.
 * nv_all above 2**VAR_ADDR_W wraps the RAM address.
 * cfg_i is sampled on start; later register changes do not affect a running sweep.
 */
module bkt_across_bin #(
    parameter int VAR_ADDR_W = 9
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start_i,
    input  bkt_pkg::bkt_cfg_t              cfg_i,
    output logic                           busy_o,
    output logic                           done_o,
    output logic [VAR_ADDR_W-1:0]          vs_raddr_o,
    input  bkt_pkg::var_state_t            vs_rdata_i,
    output logic                           vs_we_o,
    output logic [VAR_ADDR_W-1:0]          vs_waddr_o,
    output bkt_pkg::var_state_t            vs_wdata_o,
    output logic                           ls_we_o,
    output logic [bkt_pkg::VAR_LVL_W-1:0]  ls_addr_o,
    output bkt_pkg::lvl_state_t            ls_wdata_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SWEEP,
        S_DRAIN
    } state_t;

    state_t                    state;
    logic [bkt_pkg::NV_W-1:0]  cnt;
    logic                      drain_cnt;
    bkt_pkg::bkt_cfg_t         cfg_q;
    logic                      s1_vld;
    logic                      s2_vld;
    logic [VAR_ADDR_W-1:0]     s2_addr;
    logic                      is_flip;
    logic                      is_clear;
    bkt_pkg::var_state_t       flip_word;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= S_IDLE;
            cnt       <= '0;
            drain_cnt <= 1'b0;
            busy_o    <= 1'b0;
            done_o    <= 1'b0;
            s1_vld    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        state  <= S_SWEEP;
                        busy_o <= 1'b1;
                        cnt    <= '0;
                    end
                end
                S_SWEEP: begin
                    if (cnt == cfg_q.nv_all) begin
                        state     <= S_DRAIN;
                        s1_vld    <= 1'b0;
                        drain_cnt <= 1'b0;
                    end else begin
                        s1_vld <= 1'b1;
                        cnt    <= cnt + 1'b1;
                    end
                end
                S_DRAIN: begin
                    // two cycles for the last read and write to leave the pipe
                    if (drain_cnt) begin
                        state  <= S_IDLE;
                        busy_o <= 1'b0;
                        done_o <= 1'b1;
                    end else begin
                        drain_cnt <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start_i) begin
            cfg_q <= cfg_i;
        end
        if (state == S_SWEEP) begin
            vs_raddr_o <= cnt[VAR_ADDR_W-1:0];
        end
        // address travels with the returning RAM word
        s2_addr <= vs_raddr_o;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            s2_vld <= 1'b0;
        end else begin
            s2_vld <= s1_vld;
        end
    end

    always_comb begin
        is_flip  = s2_vld && vs_rdata_i.lvl == cfg_q.bkt_lvl && !vs_rdata_i.tried;
        is_clear = s2_vld && !is_flip && vs_rdata_i.lvl >= cfg_q.bkt_lvl;

        flip_word       = vs_rdata_i;
        flip_word.value = ~vs_rdata_i.value;
        flip_word.tried = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            vs_we_o <= 1'b0;
            ls_we_o <= 1'b0;
        end else begin
            vs_we_o <= is_flip || is_clear;
            ls_we_o <= is_flip;
        end
    end

    always_ff @(posedge clk) begin
        vs_waddr_o           <= s2_addr;
        vs_wdata_o           <= is_flip ? flip_word : '0;
        ls_addr_o            <= cfg_q.bkt_lvl;
        ls_wdata_o.bin_id    <= cfg_q.bkt_bin;
        ls_wdata_o.has_bkted <= 1'b1;
    end

    // RAM ports only belong to the engine while busy
    a_we_in_busy: assert property (@(posedge clk) disable iff (!rst)
        vs_we_o |-> busy_o);

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst)
        busy_o |-> !start_i);

endmodule

// File: design/bkt_csr.sv
/*
 * AXI4-Lite slave, one write and one read outstanding, full-word writes only;
 * a write with all strobes low is answered but ignored.
 * RAM windows return SLVERR while the engine is busy. level addresses wrap at
 * 2**LVL_ADDR_W.
 */
module bkt_csr #(
    parameter int VAR_ADDR_W = 9,
    parameter int LVL_ADDR_W = 9
) (
    input  logic                          clk,
    input  logic                          rst,
    input  bkt_pkg::axil_req_t            axil_req_i,
    output bkt_pkg::axil_rsp_t            axil_rsp_o,
    output bkt_pkg::bkt_cfg_t             cfg_o,
    output logic                          start_o,
    input  logic                          busy_i,
    input  logic                          done_i,
    output logic [VAR_ADDR_W-1:0]         vs_raddr_o,
    input  bkt_pkg::var_state_t           vs_rdata_i,
    output logic                          vs_we_o,
    output logic [VAR_ADDR_W-1:0]         vs_waddr_o,
    output bkt_pkg::var_state_t           vs_wdata_o,
    output logic [LVL_ADDR_W-1:0]         ls_raddr_o,
    input  bkt_pkg::lvl_state_t           ls_rdata_i,
    output logic                          ls_we_o,
    output logic [LVL_ADDR_W-1:0]         ls_waddr_o,
    output bkt_pkg::lvl_state_t           ls_wdata_o,
    input  logic [VAR_ADDR_W-1:0]         eng_vs_raddr_i,
    input  logic                          eng_vs_we_i,
    input  logic [VAR_ADDR_W-1:0]         eng_vs_waddr_i,
    input  bkt_pkg::var_state_t           eng_vs_wdata_i,
    input  logic                          eng_ls_we_i,
    input  logic [bkt_pkg::VAR_LVL_W-1:0] eng_ls_addr_i,
    input  bkt_pkg::lvl_state_t           eng_ls_wdata_i
);

    localparam int VS_W = $bits(bkt_pkg::var_state_t);
    localparam int LS_W = $bits(bkt_pkg::lvl_state_t);

    logic                  wr_acc;
    logic                  bvalid_q;
    logic [1:0]            bresp_q;
    logic                  rd_acc;
    logic                  rd_pend;
    logic                  rvalid_q;
    logic [1:0]            rresp_q;
    logic [31:0]           rdata_q;
    logic [7:0]            ar_addr_q;
    logic                  rd_busy_q;
    logic                  done_sticky;
    logic [VAR_ADDR_W-1:0] var_addr_q;
    logic [LVL_ADDR_W-1:0] lvl_addr_q;
    logic                  wr_en;
    logic                  wr_err;
    logic                  host_vs_we;
    logic                  host_ls_we;
    logic [31:0]           rd_word;
    logic                  rd_err;

    assign wr_en      = wr_acc && axil_req_i.awvalid && axil_req_i.wvalid
                        && |axil_req_i.wstrb;
    assign host_vs_we = wr_en && axil_req_i.awaddr == bkt_pkg::REG_VAR_DATA && !busy_i;
    assign host_ls_we = wr_en && axil_req_i.awaddr == bkt_pkg::REG_LVL_DATA && !busy_i;

    always_comb begin
        case (axil_req_i.awaddr)
            bkt_pkg::REG_CTRL, bkt_pkg::REG_STATUS, bkt_pkg::REG_NV_ALL,
            bkt_pkg::REG_BKT_LVL, bkt_pkg::REG_BKT_BIN,
            bkt_pkg::REG_VAR_ADDR, bkt_pkg::REG_LVL_ADDR: wr_err = 1'b0;
            bkt_pkg::REG_VAR_DATA, bkt_pkg::REG_LVL_DATA: wr_err = busy_i;
            default: wr_err = 1'b1;
        endcase
    end

    // write channel and register updates
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_acc     <= 1'b0;
            bvalid_q   <= 1'b0;
            bresp_q    <= bkt_pkg::RESP_OKAY;
            start_o    <= 1'b0;
            cfg_o      <= '0;
            var_addr_q <= '0;
            lvl_addr_q <= '0;
        end else begin
            start_o <= 1'b0;
            if (wr_acc && axil_req_i.awvalid && axil_req_i.wvalid) begin
                wr_acc   <= 1'b0;
                bvalid_q <= 1'b1;
                bresp_q  <= wr_err ? bkt_pkg::RESP_SLVERR : bkt_pkg::RESP_OKAY;
            end else if (!wr_acc && !bvalid_q && axil_req_i.awvalid
                         && axil_req_i.wvalid) begin
                wr_acc <= 1'b1;
            end else if (bvalid_q && axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end

            if (wr_en) begin
                case (axil_req_i.awaddr)
                    bkt_pkg::REG_CTRL: begin
                        // start while busy is dropped
                        start_o <= axil_req_i.wdata[0] && !busy_i;
                    end
                    bkt_pkg::REG_NV_ALL:
                        cfg_o.nv_all <= axil_req_i.wdata[bkt_pkg::NV_W-1:0];
                    bkt_pkg::REG_BKT_LVL:
                        cfg_o.bkt_lvl <= axil_req_i.wdata[bkt_pkg::VAR_LVL_W-1:0];
                    bkt_pkg::REG_BKT_BIN:
                        cfg_o.bkt_bin <= axil_req_i.wdata[bkt_pkg::BIN_ID_W-1:0];
                    bkt_pkg::REG_VAR_ADDR:
                        var_addr_q <= axil_req_i.wdata[VAR_ADDR_W-1:0];
                    bkt_pkg::REG_LVL_ADDR:
                        lvl_addr_q <= axil_req_i.wdata[LVL_ADDR_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        rd_err  = 1'b0;
        rd_word = '0;
        case (ar_addr_q)
            bkt_pkg::REG_CTRL:     rd_word = '0;
            bkt_pkg::REG_STATUS:   rd_word = {30'd0, done_sticky, busy_i | start_o};
            bkt_pkg::REG_NV_ALL:   rd_word = 32'(cfg_o.nv_all);
            bkt_pkg::REG_BKT_LVL:  rd_word = 32'(cfg_o.bkt_lvl);
            bkt_pkg::REG_BKT_BIN:  rd_word = 32'(cfg_o.bkt_bin);
            bkt_pkg::REG_VAR_ADDR: rd_word = 32'(var_addr_q);
            bkt_pkg::REG_LVL_ADDR: rd_word = 32'(lvl_addr_q);
            bkt_pkg::REG_VAR_DATA: begin
                rd_err  = rd_busy_q;
                rd_word = rd_busy_q ? '0 : 32'(vs_rdata_i);
            end
            bkt_pkg::REG_LVL_DATA: begin
                rd_err  = rd_busy_q;
                rd_word = rd_busy_q ? '0 : 32'(ls_rdata_i);
            end
            default: rd_err = 1'b1;
        endcase
    end

    // read channel, rvalid two cycles after arready so the RAM word settles
    always_ff @(posedge clk) begin
        if (!rst) begin
            rd_acc      <= 1'b0;
            rd_pend     <= 1'b0;
            rvalid_q    <= 1'b0;
            rresp_q     <= bkt_pkg::RESP_OKAY;
            rdata_q     <= '0;
            done_sticky <= 1'b0;
        end else begin
            if (rd_acc && axil_req_i.arvalid) begin
                rd_acc  <= 1'b0;
                rd_pend <= 1'b1;
            end else if (!rd_acc && !rd_pend && !rvalid_q && axil_req_i.arvalid) begin
                rd_acc <= 1'b1;
            end

            if (rd_pend) begin
                rd_pend  <= 1'b0;
                rvalid_q <= 1'b1;
                rdata_q  <= rd_word;
                rresp_q  <= rd_err ? bkt_pkg::RESP_SLVERR : bkt_pkg::RESP_OKAY;
            end else if (rvalid_q && axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end

            if (done_i) begin
                done_sticky <= 1'b1;
            end else if (rd_pend && ar_addr_q == bkt_pkg::REG_STATUS) begin
                done_sticky <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc && axil_req_i.arvalid) begin
            ar_addr_q <= axil_req_i.araddr;
            rd_busy_q <= busy_i;
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_acc;
        axil_rsp_o.wready  = wr_acc;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.arready = rd_acc;
        axil_rsp_o.rvalid  = rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
    end

    // RAM ports follow the engine while busy
    assign vs_raddr_o = busy_i ? eng_vs_raddr_i : var_addr_q;
    assign vs_we_o    = busy_i ? eng_vs_we_i : host_vs_we;
    assign vs_waddr_o = busy_i ? eng_vs_waddr_i : var_addr_q;
    assign vs_wdata_o = busy_i ? eng_vs_wdata_i
                               : bkt_pkg::var_state_t'(axil_req_i.wdata[VS_W-1:0]);
    assign ls_raddr_o = lvl_addr_q;
    assign ls_we_o    = busy_i ? eng_ls_we_i : host_ls_we;
    assign ls_waddr_o = busy_i ? eng_ls_addr_i[LVL_ADDR_W-1:0] : lvl_addr_q;
    assign ls_wdata_o = busy_i ? eng_ls_wdata_i
                               : bkt_pkg::lvl_state_t'(axil_req_i.wdata[LS_W-1:0]);

    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid);

endmodule

// File: design/bkt_top.sv
/*
 * backtrack block with host access over AXI4-Lite.
 * the host polls REG_STATUS for completion; there is no interrupt.
 */
module bkt_top #(
    parameter int VAR_ADDR_W = 9,
    parameter int LVL_ADDR_W = 9
) (
    input  logic               clk,
    input  logic               rst,
    input  bkt_pkg::axil_req_t axil_req_i,
    output bkt_pkg::axil_rsp_t axil_rsp_o
);

    bkt_pkg::bkt_cfg_t             cfg;
    logic                          start;
    logic                          busy;
    logic                          done;

    logic [VAR_ADDR_W-1:0]         vs_raddr;
    bkt_pkg::var_state_t           vs_rdata;
    logic                          vs_we;
    logic [VAR_ADDR_W-1:0]         vs_waddr;
    bkt_pkg::var_state_t           vs_wdata;
    logic [LVL_ADDR_W-1:0]         ls_raddr;
    bkt_pkg::lvl_state_t           ls_rdata;
    logic                          ls_we;
    logic [LVL_ADDR_W-1:0]         ls_waddr;
    bkt_pkg::lvl_state_t           ls_wdata;

    logic [VAR_ADDR_W-1:0]         eng_vs_raddr;
    logic                          eng_vs_we;
    logic [VAR_ADDR_W-1:0]         eng_vs_waddr;
    bkt_pkg::var_state_t           eng_vs_wdata;
    logic                          eng_ls_we;
    logic [bkt_pkg::VAR_LVL_W-1:0] eng_ls_addr;
    bkt_pkg::lvl_state_t           eng_ls_wdata;

    bkt_csr #(
        .VAR_ADDR_W(VAR_ADDR_W),
        .LVL_ADDR_W(LVL_ADDR_W)
    ) u_csr (
        .clk            (clk),
        .rst            (rst),
        .axil_req_i     (axil_req_i),
        .axil_rsp_o     (axil_rsp_o),
        .cfg_o          (cfg),
        .start_o        (start),
        .busy_i         (busy),
        .done_i         (done),
        .vs_raddr_o     (vs_raddr),
        .vs_rdata_i     (vs_rdata),
        .vs_we_o        (vs_we),
        .vs_waddr_o     (vs_waddr),
        .vs_wdata_o     (vs_wdata),
        .ls_raddr_o     (ls_raddr),
        .ls_rdata_i     (ls_rdata),
        .ls_we_o        (ls_we),
        .ls_waddr_o     (ls_waddr),
        .ls_wdata_o     (ls_wdata),
        .eng_vs_raddr_i (eng_vs_raddr),
        .eng_vs_we_i    (eng_vs_we),
        .eng_vs_waddr_i (eng_vs_waddr),
        .eng_vs_wdata_i (eng_vs_wdata),
        .eng_ls_we_i    (eng_ls_we),
        .eng_ls_addr_i  (eng_ls_addr),
        .eng_ls_wdata_i (eng_ls_wdata)
    );

    bkt_across_bin #(
        .VAR_ADDR_W(VAR_ADDR_W)
    ) u_engine (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start),
        .cfg_i      (cfg),
        .busy_o     (busy),
        .done_o     (done),
        .vs_raddr_o (eng_vs_raddr),
        .vs_rdata_i (vs_rdata),
        .vs_we_o    (eng_vs_we),
        .vs_waddr_o (eng_vs_waddr),
        .vs_wdata_o (eng_vs_wdata),
        .ls_we_o    (eng_ls_we),
        .ls_addr_o  (eng_ls_addr),
        .ls_wdata_o (eng_ls_wdata)
    );

    state_ram #(
        .word_t (bkt_pkg::var_state_t),
        .ADDR_W (VAR_ADDR_W)
    ) u_var_ram (
        .clk     (clk),
        .we_i    (vs_we),
        .waddr_i (vs_waddr),
        .wdata_i (vs_wdata),
        .raddr_i (vs_raddr),
        .rdata_o (vs_rdata)
    );

    state_ram #(
        .word_t (bkt_pkg::lvl_state_t),
        .ADDR_W (LVL_ADDR_W)
    ) u_lvl_ram (
        .clk     (clk),
        .we_i    (ls_we),
        .waddr_i (ls_waddr),
        .wdata_i (ls_wdata),
        .raddr_i (ls_raddr),
        .rdata_o (ls_rdata)
    );

endmodule

// File: verification/tb_clk_gen.sv
/*
 * free-running clock with period 10 and an active-low reset
 * held for the first 5 rising edges
 */
module tb_clk_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_o <= 1'b1;
    end

endmodule

// File: verification/bkt_tb.sv
/*
 * drives bkt_top over AXI4-Lite; keeps shadow copies of both RAMs and checks
 * every word after each sweep. the run stops at the first error.
 */
module bkt_tb;

    localparam int VAR_ADDR_W = 9;
    localparam int LVL_ADDR_W = 9;
    localparam int NUM_VARS   = 2**VAR_ADDR_W;
    localparam int NUM_LVLS   = 2**LVL_ADDR_W;
    localparam int VS_W       = $bits(bkt_pkg::var_state_t);
    localparam int LS_W       = $bits(bkt_pkg::lvl_state_t);
    localparam int WAIT_MAX   = 50;
    localparam int POLL_MAX   = 1000;

    typedef enum logic [1:0] {ACT_KEEP, ACT_CLEAR, ACT_FLIP} act_t;

    typedef struct packed {
        bkt_pkg::var_state_t got;
        bkt_pkg::var_state_t exp;
        logic [15:0]         idx;
    } var_cmp_t;

    typedef struct packed {
        bkt_pkg::lvl_state_t got;
        bkt_pkg::lvl_state_t exp;
        logic [15:0]         idx;
    } lvl_cmp_t;

    logic                clk;
    logic                rst;
    bkt_pkg::axil_req_t  req;
    bkt_pkg::axil_rsp_t  rsp;
    int                  seed = 36537;
    bkt_pkg::var_state_t var_mem [NUM_VARS];
    bkt_pkg::lvl_state_t lvl_mem [NUM_LVLS];
    var_cmp_t            var_cmp_q [$];
    lvl_cmp_t            lvl_cmp_q [$];

    tb_clk_gen u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    bkt_top #(
        .VAR_ADDR_W (VAR_ADDR_W),
        .LVL_ADDR_W (LVL_ADDR_W)
    ) u_bkt_top (
        .clk        (clk),
        .rst        (rst),
        .axil_req_i (req),
        .axil_rsp_o (rsp)
    );

    task automatic stop_on_error();
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic next_edge(inout int n, input string what);
        @(posedge clk);
        n++;
        if (n > WAIT_MAX) begin
            $display("timeout at time %0t while waiting for %s", $time, what);
            stop_on_error();
        end
    endtask

    task automatic check_var(input bkt_pkg::var_state_t got, input bkt_pkg::var_state_t exp,
                             input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s value/tried/lvl got %0d/%0b/%0d expected %0d/%0b/%0d",
                     $time, what, got.value, got.tried, got.lvl, exp.value, exp.tried, exp.lvl);
            stop_on_error();
        end
    endtask

    task automatic check_lvl(input bkt_pkg::lvl_state_t got, input bkt_pkg::lvl_state_t exp,
                             input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s bin/has_bkted got %0d/%0b expected %0d/%0b",
                     $time, what, got.bin_id, got.has_bkted, exp.bin_id, exp.has_bkted);
            stop_on_error();
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s response got %0d expected %0d",
                     $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_status(input logic [1:0] got, input logic [1:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s done/busy got %b expected %b",
                     $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // expected word after one sweep, from the flip/clear/keep rules
    function automatic bkt_pkg::var_state_t bkt_ref(
        input  bkt_pkg::var_state_t           w,
        input  logic [bkt_pkg::VAR_LVL_W-1:0] lvl,
        input  logic                          in_sweep,
        output act_t                          act
    );
        bkt_pkg::var_state_t r;
        r   = w;
        act = ACT_KEEP;
        if (in_sweep && w.lvl == lvl && !w.tried) begin
            act     = ACT_FLIP;
            r.value = ~w.value;
            r.tried = 1'b1;
        end else if (in_sweep && w.lvl >= lvl) begin
            act = ACT_CLEAR;
            r   = '0;
        end
        return r;
    endfunction

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        int n;
        @(posedge clk);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= 4'hf;
        req.bready  <= 1'b1;
        n = 0;
        do next_edge(n, "awready and wready"); while (!(rsp.awready && rsp.wready));
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        n = 0;
        do next_edge(n, "bvalid"); while (!rsp.bvalid);
        resp = rsp.bresp;
        req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        req.rready  <= 1'b1;
        n = 0;
        do next_edge(n, "arready"); while (!rsp.arready);
        req.arvalid <= 1'b0;
        n = 0;
        do next_edge(n, "rvalid"); while (!rsp.rvalid);
        data = rsp.rdata;
        resp = rsp.rresp;
        req.rready <= 1'b0;
    endtask

    task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axil_write(addr, data, resp);
        check_resp(resp, bkt_pkg::RESP_OKAY, $sformatf("write to 0x%02h", addr));
    endtask

    task automatic read_ok(input logic [7:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axil_read(addr, data, resp);
        check_resp(resp, bkt_pkg::RESP_OKAY, $sformatf("read from 0x%02h", addr));
    endtask

    // read every RAM word back and queue it for the compare process
    task automatic check_all();
        logic [31:0] d;
        for (int i = 0; i < NUM_VARS; i++) begin
            write_ok(bkt_pkg::REG_VAR_ADDR, i);
            read_ok(bkt_pkg::REG_VAR_DATA, d);
            var_cmp_q.push_back(var_cmp_t'{d[VS_W-1:0], var_mem[i], 16'(i)});
        end
        for (int i = 0; i < NUM_LVLS; i++) begin
            write_ok(bkt_pkg::REG_LVL_ADDR, i);
            read_ok(bkt_pkg::REG_LVL_DATA, d);
            lvl_cmp_q.push_back(lvl_cmp_t'{d[LS_W-1:0], lvl_mem[i], 16'(i)});
        end
    endtask

    task automatic start_sweep(input int nv, input logic [15:0] lvl, input logic [9:0] bin);
        write_ok(bkt_pkg::REG_NV_ALL, nv);
        write_ok(bkt_pkg::REG_BKT_LVL, 32'(lvl));
        write_ok(bkt_pkg::REG_BKT_BIN, 32'(bin));
        write_ok(bkt_pkg::REG_CTRL, 32'd1);
    endtask

    task automatic finish_sweep(input int nv, input logic [15:0] lvl, input logic [9:0] bin);
        logic [31:0] st;
        act_t        act;
        int          n;
        int          flips;
        n = 0;
        do begin
            read_ok(bkt_pkg::REG_STATUS, st);
            n++;
            if (n > POLL_MAX) begin
                $display("timeout at time %0t, done never set in REG_STATUS", $time);
                stop_on_error();
            end
        end while (!st[1]);
        check_status(st[1:0], 2'b10, "first status read after done");
        read_ok(bkt_pkg::REG_STATUS, st);
        check_status(st[1:0], 2'b00, "second status read after done");
        flips = 0;
        for (int i = 0; i < NUM_VARS; i++) begin
            var_mem[i] = bkt_ref(var_mem[i], lvl, i < nv, act);
            if (act == ACT_FLIP) flips++;
        end
        if (flips > 0) begin
            lvl_mem[lvl[LVL_ADDR_W-1:0]] = '{bin, 1'b1};
        end
        check_all();
    endtask

    always @(posedge clk) begin : compare_proc
        var_cmp_t vc;
        lvl_cmp_t lc;
        if (var_cmp_q.size() > 0) begin
            vc = var_cmp_q.pop_front();
            check_var(vc.got, vc.exp, $sformatf("var[%0d]", vc.idx));
        end
        if (lvl_cmp_q.size() > 0) begin
            lc = lvl_cmp_q.pop_front();
            check_lvl(lc.got, lc.exp, $sformatf("lvl[%0d]", lc.idx));
        end
    end

    initial begin : stimulus
        int                  n;
        logic [1:0]          resp;
        logic [31:0]         d;
        bkt_pkg::var_state_t w;
        logic [15:0]         lvl;
        logic [9:0]          bin;

        req = '0;
        n   = 0;
        do next_edge(n, "reset release"); while (rst !== 1'b1);

        // levels spread two either side of the first backtrack level
        lvl = 16'd37;
        for (int i = 0; i < NUM_VARS; i++) begin
            w     = VS_W'($random(seed));
            w.lvl = lvl + 16'($random(seed) % 3);
            // at least one flip in the first sweep
            if (i == 0) begin
                w.lvl   = lvl;
                w.tried = 1'b0;
            end
            var_mem[i] = w;
            write_ok(bkt_pkg::REG_VAR_ADDR, i);
            write_ok(bkt_pkg::REG_VAR_DATA, 32'(w));
        end
        for (int i = 0; i < NUM_LVLS; i++) begin
            lvl_mem[i] = LS_W'($random(seed));
            write_ok(bkt_pkg::REG_LVL_ADDR, i);
            write_ok(bkt_pkg::REG_LVL_DATA, 32'(lvl_mem[i]));
        end
        check_all();

        bin = 10'($random(seed));
        start_sweep(300, lvl, bin);
        finish_sweep(300, lvl, bin);

        // same level again, no untried word left there
        bin = 10'($random(seed));
        start_sweep(300, lvl, bin);
        finish_sweep(300, lvl, bin);

        // full sweep at level 0 with host access while busy
        write_ok(bkt_pkg::REG_VAR_ADDR, 5);
        bin = 10'($random(seed));
        start_sweep(NUM_VARS, 16'd0, bin);
        // an untried level-0 word, flipped by the sweep if it got in
        w = '{value: 2'b01, tried: 1'b0, lvl: 16'd0};
        axil_write(bkt_pkg::REG_VAR_DATA, 32'(w), resp);
        check_resp(resp, bkt_pkg::RESP_SLVERR, "data window write while busy");
        read_ok(bkt_pkg::REG_STATUS, d);
        check_status(d[1:0], 2'b01, "status read while busy");
        finish_sweep(NUM_VARS, 16'd0, bin);

        bin = 10'($random(seed));
        start_sweep(0, lvl, bin);
        finish_sweep(0, lvl, bin);

        n = 0;
        while (var_cmp_q.size() != 0 || lvl_cmp_q.size() != 0) begin
            next_edge(n, "compare queues to drain");
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: bkt_top.f
design/bkt_pkg.sv
design/state_ram.sv
design/bkt_across_bin.sv
design/bkt_csr.sv
design/bkt_top.sv
verification/tb_clk_gen.sv
verification/bkt_tb.sv
